/* tests/captureCases.txt */
# kind offset value: W writes a register, R reads one and compares with value (hex)
# F mode count: mode 0 progressive, mode 1 line doubler, count frames to run
R 00 00000000
W 00 FC14FC04
W 04 000C0002
W 08 000E0002
W 0C 010C0000
W 10 80088010
W 14 00000400
W 18 00000028
W 1C 12345678
R 00 00140004
R 04 000C0002
R 08 000E0002
R 0C 010C0000
R 10 00080010
R 14 00000400
R 18 00000028
R 1C 00000000
F 0 2
F 1 1
W 18 00000090
F 0 1
W 14 00000040
W 18 00000028
R 14 00000040
F 0 1

/* flist.f */
src/videoPkg.sv
src/captureCfgPkg.sv
src/captureConfigRegs.sv
src/captureWriter.sv
src/lineBufferRam.sv
src/videoCaptureTop.sv
tests/videoCaptureTb.sv

/* tests/videoCaptureTb.sv */
`timescale 1ns/100ps

module videoCaptureTb;
    import videoPkg::*;
    import captureCfgPkg::*;

    localparam int ramAddrWidth  = 10;
    localparam int ramWords      = 1 << ramAddrWidth;
    localparam int lineClocks    = 48;
    localparam int axiWaitLimit  = 32;
    localparam logic [11:0] idle = 12'hFFF; // Never inside a window.

    logic                    clock;
    logic                    rstN;
    axiLiteReqT              axiReq;
    axiLiteRspT              axiRsp;
    videoInT                 videoIn;
    logic                    lineDoubler;
    logic [ramAddrWidth-1:0] rdAddr;
    pixelT                   rdData;
    logic                    startTrigger;

    logic [15:0] lfsrState = 16'd60387;
    logic [31:0] regShadow [7];
    pixelT       modelRam [ramWords];
    logic        modelValid [ramWords];
    logic [14:0] modelBase;
    logic [14:0] modelAddr;
    logic [11:0] modelPrevX;
    logic        modelTrigPrev;
    logic        dutTrigPrev;
    int          frameIndex;
    int          cycleCount;
    int          cycleLimit = 1000000;
    int          pixelErrors;
    int          regErrors;
    int          triggerErrors;
    int          otherErrors;
    byte         caseKinds [$];
    logic [31:0] caseArgA [$];
    logic [31:0] caseArgB [$];

    videoCaptureTop #(
        .ramAddrWidth (ramAddrWidth)
    ) u_videoCaptureTop (
        .clock        (clock),
        .rstN         (rstN),
        .axiReq       (axiReq),
        .axiRsp       (axiRsp),
        .videoIn      (videoIn),
        .lineDoubler  (lineDoubler),
        .rdAddr       (rdAddr),
        .rdData       (rdData),
        .startTrigger (startTrigger)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Run timed out after %0d cycles", cycleCount);
            $display("Checks failed");
            $finish;
        end
    end

    // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic nextRandomBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic logic isMappedOffset(logic [7:0] offset);
        return (offset[1:0] == 2'b00) && (offset <= 8'h18);
    endfunction

    function automatic logic [31:0] regMask(logic [7:0] offset);
        if (offset <= 8'h0C) begin
            return 32'h03FF03FF; // Window limits are 10 bits each.
        end else if (offset == 8'h10) begin
            return 32'h7FFF7FFF;
        end
        return 32'h00007FFF;
    endfunction

    // Applies the capture rules to one sample; returns 1 where a trigger pulse begins.
    function automatic logic advanceModel(logic mode, logic [11:0] x, logic [11:0] y,
                                          pixelT pix);
        logic [31:0] hReg;
        logic [31:0] vReg;
        logic [11:0] hStart;
        logic [11:0] hEnd;
        logic [11:0] vStart;
        logic [11:0] vEnd;
        logic [11:0] lineOffset;
        logic [11:0] pixelOffset;
        logic [14:0] baseLimit;
        logic [14:0] addr;
        logic        vertical;
        logic        trig;
        logic        rising;
        hReg   = mode ? regShadow[2] : regShadow[0];
        vReg   = mode ? regShadow[3] : regShadow[1];
        hStart = {2'd0, hReg[9:0]};
        hEnd   = {2'd0, hReg[25:16]};
        vStart = {2'd0, vReg[9:0]};
        vEnd   = {2'd0, vReg[25:16]};
        if (mode) begin
            vertical = (y < 12'd240) || (y >= 12'd263 && y < vEnd);
        end else begin
            vertical = (y >= vStart) && (y < vEnd);
        end
        trig = 1'b0;
        if (vertical && x >= hStart && x < hEnd) begin
            pixelOffset = x - hStart;
            lineOffset  = y - vStart;
            addr        = modelBase + {3'd0, pixelOffset};
            trig        = ({3'd0, lineOffset} < regShadow[4][30:16])
                       && (modelAddr == regShadow[6][14:0]);
            modelRam[addr[ramAddrWidth-1:0]]   = pix;
            modelValid[addr[ramAddrWidth-1:0]] = 1'b1;
            modelAddr = addr;
        end
        if (modelPrevX == hEnd && x == hEnd) begin
            baseLimit = regShadow[5][14:0] - regShadow[4][14:0];
            modelBase = (vertical && modelBase < baseLimit) ? modelBase + regShadow[4][14:0]
                                                            : 15'd0;
        end
        modelPrevX    = x;
        rising        = trig && !modelTrigPrev;
        modelTrigPrev = trig;
        return rising;
    endfunction

    task automatic waitCycle();
        @(posedge clock);
        #1;
    endtask

    task automatic checkPixel(string testName, pixelT expected, pixelT actual);
        if (actual !== expected) begin
            pixelErrors++;
            $display("[FAIL] %s expected %06h actual %06h", testName, expected, actual);
        end
    endtask

    task automatic checkReg(string testName, logic [31:0] expWord, logic [1:0] expResp,
                            logic [31:0] actWord, logic [1:0] actResp);
        if (actWord !== expWord || actResp !== expResp) begin
            regErrors++;
            $display("[FAIL] %s expected data %08h resp %0d actual data %08h resp %0d",
                     testName, expWord, expResp, actWord, actResp);
        end
    endtask

    task automatic checkResp(string testName, logic [1:0] expected, logic [1:0] actual);
        if (actual !== expected) begin
            regErrors++;
            $display("[FAIL] %s expected resp %0d actual resp %0d", testName, expected, actual);
        end
    endtask

    task automatic checkTrigger(string testName, int expected, int actual);
        if (actual != expected) begin
            triggerErrors++;
            $display("[FAIL] %s expected %0d pulses actual %0d", testName, expected, actual);
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (3) waitCycle();
        rstN          = 1'b1;
        modelBase     = '0;
        modelAddr     = '0;
        modelPrevX    = idle;
        modelTrigPrev = 1'b0;
        dutTrigPrev   = 1'b0;
        foreach (regShadow[i]) begin
            regShadow[i] = '0;
        end
    endtask

    task automatic axiWrite(logic [7:0] offset, logic [31:0] value);
        int         waited;
        logic       done;
        logic [1:0] resp;
        axiReq.awaddr  = offset;
        axiReq.wdata   = value;
        axiReq.wstrb   = 4'hF;
        axiReq.awvalid = 1'b1;
        axiReq.wvalid  = 1'b1;
        waited = 0;
        while (!(axiRsp.awready && axiRsp.wready) && waited < axiWaitLimit) begin
            waitCycle();
            waited++;
        end
        waitCycle();
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
        done = 1'b0;
        while (!done && waited < axiWaitLimit) begin
            axiReq.bready = nextRandomBit(); // Random stall on the response.
            done = axiRsp.bvalid && axiReq.bready;
            resp = axiRsp.bresp;
            waitCycle();
            waited++;
        end
        axiReq.bready = 1'b0;
        if (!done) begin
            otherErrors++;
            $display("Write to offset 0x%02h got no response", offset);
        end else begin
            checkResp($sformatf("write 0x%02h", offset),
                      isMappedOffset(offset) ? respOkay : respSlvErr, resp);
            if (isMappedOffset(offset)) begin
                regShadow[offset[4:2]] = value & regMask(offset);
            end
        end
    endtask

    task automatic axiRead(logic [7:0] offset, logic [31:0] expected);
        int          waited;
        logic        done;
        logic [31:0] word;
        logic [1:0]  resp;
        axiReq.araddr  = offset;
        axiReq.arvalid = 1'b1;
        waited = 0;
        while (!axiRsp.arready && waited < axiWaitLimit) begin
            waitCycle();
            waited++;
        end
        waitCycle();
        axiReq.arvalid = 1'b0;
        done = 1'b0;
        while (!done && waited < axiWaitLimit) begin
            axiReq.rready = nextRandomBit();
            done = axiRsp.rvalid && axiReq.rready;
            word = axiRsp.rdata;
            resp = axiRsp.rresp;
            waitCycle();
            waited++;
        end
        axiReq.rready = 1'b0;
        if (!done) begin
            otherErrors++;
            $display("Read of offset 0x%02h got no response", offset);
        end else begin
            checkReg($sformatf("read 0x%02h", offset), expected,
                     isMappedOffset(offset) ? respOkay : respSlvErr, word, resp);
        end
    endtask

    task automatic readBackRam(string tag);
        for (int a = 0; a < ramWords; a++) begin
            rdAddr = a[ramAddrWidth-1:0];
            waitCycle();
            if (modelValid[a]) begin
                checkPixel($sformatf("%s addr %0d", tag, a), modelRam[a], rdData);
            end
        end
    endtask

    task automatic runFrames(logic mode, int count);
        int          lines;
        int          pulsesSeen;
        int          pulsesExpected;
        logic [11:0] x;
        logic [11:0] y;
        pixelT       pix;
        lines       = mode ? 270 : 24;
        lineDoubler = mode;
        for (int f = 0; f < count; f++) begin
            pulsesSeen     = 0;
            pulsesExpected = 0;
            frameIndex++;
            for (int row = 0; row < lines; row++) begin
                for (int c = 0; c < lineClocks; c++) begin
                    x       = 12'(c / 2); // Each x value lasts two clocks.
                    y       = 12'(row);
                    pix     = {x[7:0], y[7:0], frameIndex[7:0]};
                    videoIn = {x, y, pix};
                    if (advanceModel(mode, x, y, pix)) begin
                        pulsesExpected++;
                    end
                    waitCycle();
                    if (startTrigger && !dutTrigPrev) begin
                        pulsesSeen++;
                    end
                    dutTrigPrev = startTrigger;
                end
            end
            checkTrigger($sformatf("frame %0d trigger", frameIndex), pulsesExpected, pulsesSeen);
        end
        videoIn    = {idle, idle, 24'd0};
        modelPrevX = idle;
        readBackRam($sformatf("frame %0d", frameIndex));
    endtask

    initial begin
        int          fd;
        int          cycleSum;
        int          errorTotal;
        string       line;
        byte         kind;
        logic [31:0] argA;
        logic [31:0] argB;
        clock       = 1'b0;
        rstN        = 1'b0;
        axiReq      = '0;
        videoIn     = {idle, idle, 24'd0};
        lineDoubler = 1'b0;
        rdAddr      = '0;
        foreach (modelValid[i]) begin
            modelValid[i] = 1'b0;
        end
        cycleSum = 8 + 294 * lineClocks + 2 * (ramWords + 2); // Resets and the closing frames.
        fd = $fopen("tests/captureCases.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("Cannot open tests/captureCases.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%c %h %h", kind, argA, argB) == 3) begin
                    caseKinds.push_back(kind);
                    caseArgA.push_back(argA);
                    caseArgB.push_back(argB);
                    if (kind == "F") begin
                        cycleSum += argB * (argA[0] ? 270 : 24) * lineClocks + ramWords + 2;
                    end else begin
                        cycleSum += 2 * axiWaitLimit + 2;
                    end
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        cycleLimit = 2 * cycleSum;
        applyReset();
        foreach (caseKinds[i]) begin
            case (caseKinds[i])
                "W": axiWrite(caseArgA[i][7:0], caseArgB[i]);
                "R": axiRead(caseArgA[i][7:0], caseArgB[i]);
                "F": runFrames(caseArgA[i][0], caseArgB[i]);
                default: begin
                    otherErrors++;
                    $display("Unknown case kind %c on entry %0d", caseKinds[i], i);
                end
            endcase
        end
        // With no configuration after reset the earlier RAM contents survive.
        applyReset();
        runFrames(1'b0, 1);
        runFrames(1'b1, 1);
        errorTotal = pixelErrors + regErrors + triggerErrors + otherErrors;
        $display("Errors: %0d pixel, %0d register, %0d trigger, %0d other",
                 pixelErrors, regErrors, triggerErrors, otherErrors);
        if (errorTotal == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src/videoCaptureTop.sv */
`timescale 1ns/100ps

module videoCaptureTop #(
    parameter int ramAddrWidth = 15
) (
    input  logic                      clock,
    input  logic                      rstN,
    input  captureCfgPkg::axiLiteReqT axiReq,
    output captureCfgPkg::axiLiteRspT axiRsp,
    input  videoPkg::videoInT         videoIn,
    input  logic                      lineDoubler,
    input  logic [ramAddrWidth-1:0]   rdAddr,
    output videoPkg::pixelT           rdData,
    output logic                      startTrigger
);
    import videoPkg::*;
    import captureCfgPkg::*;

    captureCfgT              cfg;
    logic                    wrEnable;
    logic [ramAddrWidth-1:0] wrAddr;
    pixelT                   wrData;

    captureConfigRegs u_captureConfigRegs (
        .clock  (clock),
        .rstN   (rstN),
        .axiReq (axiReq),
        .axiRsp (axiRsp),
        .cfg    (cfg)
    );

    captureWriter #(
        .ramAddrWidth (ramAddrWidth)
    ) u_captureWriter (
        .clock        (clock),
        .rstN         (rstN),
        .videoIn      (videoIn),
        .lineDoubler  (lineDoubler),
        .cfg          (cfg),
        .wrEnable     (wrEnable),
        .wrAddr       (wrAddr),
        .wrData       (wrData),
        .startTrigger (startTrigger)
    );

    lineBufferRam #(
        .ramAddrWidth (ramAddrWidth)
    ) u_lineBufferRam (
        .clock    (clock),
        .wrEnable (wrEnable),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .rdAddr   (rdAddr),
        .rdData   (rdData)
    );

endmodule

/* src/lineBufferRam.sv */
`timescale 1ns/100ps

module lineBufferRam #(
    parameter int ramAddrWidth = 15
) (
    input  logic                    clock,
    input  logic                    wrEnable,
    input  logic [ramAddrWidth-1:0] wrAddr,
    input  videoPkg::pixelT         wrData,
    input  logic [ramAddrWidth-1:0] rdAddr,
    output videoPkg::pixelT         rdData
);
    import videoPkg::*;

    localparam int numWords = 2 ** ramAddrWidth;

    pixelT memory [numWords];

    always_ff @(posedge clock) begin
        if (wrEnable) begin
            memory[wrAddr] <= wrData;
        end
    end

    // Old data on a same-address collision.
    always_ff @(posedge clock) begin
        rdData <= memory[rdAddr];
    end

endmodule

/* src/captureWriter.sv */
`timescale 1ns/100ps

module captureWriter #(
    parameter int ramAddrWidth = 15
) (
    input  logic                      clock,
    input  logic                      rstN,
    input  videoPkg::videoInT         videoIn,
    input  logic                      lineDoubler,
    input  captureCfgPkg::captureCfgT cfg,
    output logic                      wrEnable,
    output logic [ramAddrWidth-1:0]   wrAddr,
    output videoPkg::pixelT           wrData,
    output logic                      startTrigger
);
    import videoPkg::*;
    import captureCfgPkg::*;

    captureModeT mode;
    windowT      window;
    positionT    posX;
    positionT    posY;
    positionT    prevX;
    positionT    hStart;
    positionT    hEnd;
    positionT    vStart;
    positionT    vEnd;
    positionT    lineOffset;
    logic        verticalCapture;
    logic        capture;
    logic        lineEnd;
    logic        firstBuffer;
    logic [14:0] lineBase;
    logic [14:0] addrFull;
    logic [14:0] nextAddr;

    assign mode   = lineDoubler ? captureLineDoubler : captureProgressive;
    assign window = (mode == captureLineDoubler) ? cfg.interlaced : cfg.progressive;
    assign posX   = videoIn.counterX;
    assign posY   = videoIn.counterY;
    assign hStart = positionT'(window.hStart);
    assign hEnd   = positionT'(window.hEnd);
    assign vStart = positionT'(window.vStart);
    assign vEnd   = positionT'(window.vEnd);

    always_comb begin
        if (mode == captureLineDoubler) begin
            // Both fields go into the same buffer.
            verticalCapture = (posY < fieldOneLastLine)
                           || (posY >= fieldTwoFirstLine && posY < vEnd);
        end else begin
            verticalCapture = (posY >= vStart) && (posY < vEnd);
        end
    end

    assign capture     = verticalCapture && (posX >= hStart) && (posX < hEnd);
    assign lineEnd     = (prevX == hEnd) && (posX == hEnd); // Once per line.
    assign lineOffset  = posY - vStart;
    assign firstBuffer = {3'd0, lineOffset} < cfg.bufferSize;
    assign nextAddr    = lineBase + {3'd0, posX - hStart};

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            prevX        <= '0;
            lineBase     <= '0;
            addrFull     <= '0;
            wrEnable     <= 1'b0;
            startTrigger <= 1'b0;
        end else begin
            prevX <= posX;
            if (lineEnd) begin
                if (verticalCapture && lineBase < cfg.ramNumWords - cfg.bufferLineLength) begin
                    lineBase <= lineBase + cfg.bufferLineLength;
                end else begin
                    lineBase <= '0; // Wrap to the start of RAM.
                end
            end
            wrEnable <= capture;
            if (capture) begin
                addrFull     <= nextAddr;
                // Fires on the write after the trigger address.
                startTrigger <= firstBuffer && (addrFull == cfg.triggerAddress);
            end else begin
                startTrigger <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            wrData <= videoIn.pixel;
        end
    end

    assign wrAddr = addrFull[ramAddrWidth-1:0];

endmodule

/* src/captureConfigRegs.sv */
`timescale 1ns/100ps

module captureConfigRegs (
    input  logic                      clock,
    input  logic                      rstN,
    input  captureCfgPkg::axiLiteReqT axiReq,
    output captureCfgPkg::axiLiteRspT axiRsp,
    output captureCfgPkg::captureCfgT cfg
);
    import captureCfgPkg::*;

    captureCfgT  cfgReg;
    logic        writeReady;
    logic        readReady;
    logic        bValid;
    logic [1:0]  bResp;
    logic        rValid;
    logic [1:0]  rResp;
    logic [31:0] rData;
    logic        writeAccept;
    logic        readAccept;
    logic        bValidNext;
    logic        rValidNext;
    logic [31:0] writeWord;

    function automatic logic isMapped(logic [7:0] addr);
        return addr inside {regProgH, regProgV, regIntH, regIntV,
                            regLineGeom, regRamWords, regTrigger};
    endfunction

    // Register image as seen on the bus.
    function automatic logic [31:0] regImage(captureCfgT c, logic [7:0] addr);
        logic [31:0] image;
        case (addr)
            regProgH:    image = {6'd0, c.progressive.hEnd, 6'd0, c.progressive.hStart};
            regProgV:    image = {6'd0, c.progressive.vEnd, 6'd0, c.progressive.vStart};
            regIntH:     image = {6'd0, c.interlaced.hEnd, 6'd0, c.interlaced.hStart};
            regIntV:     image = {6'd0, c.interlaced.vEnd, 6'd0, c.interlaced.vStart};
            regLineGeom: image = {1'b0, c.bufferSize, 1'b0, c.bufferLineLength};
            regRamWords: image = {17'd0, c.ramNumWords};
            regTrigger:  image = {17'd0, c.triggerAddress};
            default:     image = '0;
        endcase
        return image;
    endfunction

    function automatic logic [31:0] mergeBytes(logic [31:0] oldWord, logic [31:0] newWord,
                                               logic [3:0] strobe);
        logic [31:0] merged;
        for (int lane = 0; lane < 4; lane++) begin
            merged[8*lane +: 8] = strobe[lane] ? newWord[8*lane +: 8] : oldWord[8*lane +: 8];
        end
        return merged;
    endfunction

    assign writeAccept = writeReady && axiReq.awvalid && axiReq.wvalid;
    assign readAccept  = readReady && axiReq.arvalid;
    assign bValidNext  = bValid ? !axiReq.bready : writeAccept;
    assign rValidNext  = rValid ? !axiReq.rready : readAccept;
    assign writeWord   = mergeBytes(regImage(cfgReg, axiReq.awaddr), axiReq.wdata, axiReq.wstrb);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            writeReady <= 1'b0;
            readReady  <= 1'b0;
            bValid     <= 1'b0;
            bResp      <= respOkay;
            rValid     <= 1'b0;
            rResp      <= respOkay;
        end else begin
            writeReady <= !bValidNext; // Blocked while a response waits.
            readReady  <= !rValidNext;
            bValid     <= bValidNext;
            rValid     <= rValidNext;
            if (writeAccept) begin
                bResp <= isMapped(axiReq.awaddr) ? respOkay : respSlvErr;
            end
            if (readAccept) begin
                rResp <= isMapped(axiReq.araddr) ? respOkay : respSlvErr;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (readAccept) begin
            rData <= regImage(cfgReg, axiReq.araddr); // Zero for unmapped offsets.
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            cfgReg <= '0;
        end else if (writeAccept) begin
            case (axiReq.awaddr)
                regProgH: begin
                    cfgReg.progressive.hStart <= writeWord[9:0];
                    cfgReg.progressive.hEnd   <= writeWord[25:16];
                end
                regProgV: begin
                    cfgReg.progressive.vStart <= writeWord[9:0];
                    cfgReg.progressive.vEnd   <= writeWord[25:16];
                end
                regIntH: begin
                    cfgReg.interlaced.hStart <= writeWord[9:0];
                    cfgReg.interlaced.hEnd   <= writeWord[25:16];
                end
                regIntV: begin
                    cfgReg.interlaced.vStart <= writeWord[9:0];
                    cfgReg.interlaced.vEnd   <= writeWord[25:16];
                end
                regLineGeom: begin
                    cfgReg.bufferLineLength <= writeWord[14:0];
                    cfgReg.bufferSize       <= writeWord[30:16];
                end
                regRamWords: cfgReg.ramNumWords    <= writeWord[14:0];
                regTrigger:  cfgReg.triggerAddress <= writeWord[14:0];
                default: ; // Unmapped writes are dropped.
            endcase
        end
    end

    assign axiRsp.awready = writeReady;
    assign axiRsp.wready  = writeReady;
    assign axiRsp.bvalid  = bValid;
    assign axiRsp.bresp   = bResp;
    assign axiRsp.arready = readReady;
    assign axiRsp.rvalid  = rValid;
    assign axiRsp.rdata   = rData;
    assign axiRsp.rresp   = rResp;
    assign cfg            = cfgReg;

endmodule

/* src/captureCfgPkg.sv */
package captureCfgPkg;

    typedef struct packed {
        logic [9:0] hStart;
        logic [9:0] hEnd;
        logic [9:0] vStart;
        logic [9:0] vEnd;
    } windowT;

    typedef struct packed {
        windowT      progressive;
        windowT      interlaced;
        logic [14:0] bufferLineLength;
        logic [14:0] bufferSize;
        logic [14:0] ramNumWords;
        logic [14:0] triggerAddress;
    } captureCfgT;

    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axiLiteReqT;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiLiteRspT;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    localparam logic [7:0] regProgH    = 8'h00;
    localparam logic [7:0] regProgV    = 8'h04;
    localparam logic [7:0] regIntH     = 8'h08;
    localparam logic [7:0] regIntV     = 8'h0C;
    localparam logic [7:0] regLineGeom = 8'h10;
    localparam logic [7:0] regRamWords = 8'h14;
    localparam logic [7:0] regTrigger  = 8'h18;

endpackage

/* src/videoPkg.sv */
package videoPkg;

    // Counter width of the incoming timing.
    typedef logic [11:0] positionT;

    // Field order matches the RAM word layout.
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixelT;

    typedef struct packed {
        positionT counterX;
        positionT counterY;
        pixelT    pixel;
    } videoInT;

    typedef enum logic {
        captureProgressive,
        captureLineDoubler
    } captureModeT;

    // First field ends here when line doubling.
    localparam positionT fieldOneLastLine = 12'd240;
    // Second field starts here when line doubling.
    localparam positionT fieldTwoFirstLine = 12'd263;

endpackage
